// File: common/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and address width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_REG_COUNT 32

// Instruction memory depth in words
`define RV_IMEM_WORDS 1024

// Data memory depth in words
`define RV_DMEM_WORDS 1024

`endif

// File: common/rv_pkg.sv
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;                   // Data word or byte address
    typedef logic [4:0] reg_idx_t;                         // Register number
    typedef logic [$clog2(`RV_IMEM_WORDS)-1:0] imem_addr_t; // Word index into instruction memory
    typedef logic [2:0] funct3_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

endpackage

`default_nettype wire

// File: src/pc_counter.sv
`timescale 1ns/100ps
`default_nettype none

module pc_counter (
    input  wire           clk,
    input  wire           reset,
    input  logic          branch_taken,
    input  rv_pkg::word_t branch_target,
    output rv_pkg::word_t pc
);
    import rv_pkg::*;

    word_t next_pc;

    // Taken branch wins over sequential fetch
    assign next_pc = branch_taken ? branch_target : pc + 32'd4;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0; // First fetch from address 0
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: src/instr_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module instr_mem (
    input  wire                clk,
    input  logic               load_en,
    input  rv_pkg::imem_addr_t load_addr,
    input  rv_pkg::word_t      load_data,
    input  rv_pkg::word_t      pc,
    output rv_pkg::word_t      instr
);
    import rv_pkg::*;

    word_t      mem [`RV_IMEM_WORDS];
    imem_addr_t fetch_idx;

    // Empty memory decodes as an unknown opcode, so it runs as a no-op
    initial begin
        for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    assign fetch_idx = pc[$bits(imem_addr_t)+1:2]; // Drop the byte offset
    assign instr     = mem[fetch_idx];

endmodule

`default_nettype wire

// File: decode/control_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module control_decoder (
    input  rv_pkg::word_t   instr,
    output logic            reg_write,
    output logic            mem_read,
    output logic            mem_write,
    output logic            alu_src,
    output logic            branch,
    output rv_pkg::alu_op_t alu_op,
    output rv_pkg::word_t   imm
);
    import rv_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    funct7_b5;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;

    // Register forms honour sub; sra/srai share the same funct7 bit
    function automatic alu_op_t arith_op(input funct3_t f3, input logic alt,
                                         input logic is_reg);
        alu_op_t op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode    = opcode_t'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    // Sign-extended immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        alu_src   = 1'b0;
        branch    = 1'b0;
        alu_op    = ALU_ADD;
        imm       = '0;

        case (opcode)
            OP: begin
                reg_write = 1'b1;
                alu_op    = arith_op(funct3, funct7_b5, 1'b1);
            end
            OP_IMM: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = arith_op(funct3, funct7_b5, 1'b0);
                imm       = imm_i;
            end
            LOAD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_i; // Address is rs1 + offset
            end
            STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_s;
            end
            BRANCH: begin
                branch = 1'b1;
                imm    = imm_b;
            end
            default: begin
                // Unsupported opcode, strobes stay low
            end
        endcase
    end

endmodule

`default_nettype wire

// File: decode/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module reg_file (
    input  wire              clk,
    input  wire              reset,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  logic             write_en,
    input  rv_pkg::word_t    write_data,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd != '0) begin
            regs[rd] <= write_data; // x0 never written, stays zero
        end
    end

    // Combinational read ports
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t alu_op,
    output rv_pkg::word_t   result
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0]; // Upper bits of the shift amount ignored
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'd0, lt_signed};
            ALU_SLTU: result = {31'd0, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt; // Sign bit fills from the left
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: execute/branch_compare.sv
`timescale 1ns/100ps
`default_nettype none

module branch_compare (
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    input  rv_pkg::funct3_t funct3,
    input  logic            branch,
    output logic            branch_taken
);
    logic cond;

    always_comb begin
        case (funct3)
            3'b000:  cond = rs1_data == rs2_data;                   // beq
            3'b001:  cond = rs1_data != rs2_data;                   // bne
            3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);  // blt
            3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data); // bge
            3'b110:  cond = rs1_data < rs2_data;                    // bltu
            3'b111:  cond = rs1_data >= rs2_data;                   // bgeu
            default: cond = 1'b0; // Codes 010 and 011 are undefined
        endcase
    end

    assign branch_taken = branch & cond;

endmodule

`default_nettype wire

// File: src/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module data_mem (
    input  wire           clk,
    input  rv_pkg::word_t addr,
    input  rv_pkg::word_t write_data,
    input  logic          write_en,
    output rv_pkg::word_t read_data
);
    import rv_pkg::*;

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

    word_t            mem [`RV_DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;

    // Unwritten locations read back as zero
    initial begin
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign word_idx = addr[IDX_W+1:2]; // Higher address bits wrap

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[word_idx] <= write_data;
        end
    end

    assign read_data = mem[word_idx];

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
    input  wire                clk,
    input  wire                reset,
    input  logic               load_en,
    input  rv_pkg::imem_addr_t load_addr,
    input  rv_pkg::word_t      load_data,
    output rv_pkg::word_t      pc,
    output logic               retire_valid,
    output rv_pkg::reg_idx_t   retire_rd,
    output rv_pkg::word_t      retire_data,
    output logic               store_valid,
    output rv_pkg::word_t      store_addr,
    output rv_pkg::word_t      store_data
);
    import rv_pkg::*;

    word_t    instr;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     alu_src;
    logic     branch;
    alu_op_t  alu_op;
    word_t    imm;
    reg_idx_t rd;
    funct3_t  funct3;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    operand_b;
    word_t    alu_result;
    word_t    read_data;
    word_t    write_back;
    word_t    branch_target;
    logic     branch_taken;

    pc_counter u_pc (.clk(clk), .reset(reset), .branch_taken(branch_taken),
                     .branch_target(branch_target), .pc(pc));

    // Program load only while the core is held in reset
    instr_mem u_imem (.clk(clk), .load_en(load_en & reset), .load_addr(load_addr),
                      .load_data(load_data), .pc(pc), .instr(instr));

    control_decoder u_dec (.instr(instr), .reg_write(reg_write), .mem_read(mem_read),
                           .mem_write(mem_write), .alu_src(alu_src), .branch(branch),
                           .alu_op(alu_op), .imm(imm));

    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    reg_file u_rf (.clk(clk), .reset(reset), .rs1(instr[19:15]), .rs2(instr[24:20]),
                   .rd(rd), .write_en(reg_write), .write_data(write_back),
                   .rs1_data(rs1_data), .rs2_data(rs2_data));

    assign operand_b     = alu_src ? imm : rs2_data;
    assign branch_target = pc + imm;

    alu u_alu (.a(rs1_data), .b(operand_b), .alu_op(alu_op), .result(alu_result));

    branch_compare u_br (.rs1_data(rs1_data), .rs2_data(rs2_data), .funct3(funct3),
                         .branch(branch), .branch_taken(branch_taken));

    // Store strobe doubles as the memory write enable
    data_mem u_dmem (.clk(clk), .addr(alu_result), .write_data(rs2_data),
                     .write_en(store_valid), .read_data(read_data));

    assign write_back = mem_read ? read_data : alu_result;

    // Observation ports
    assign retire_valid = reg_write & (rd != '0) & ~reset;
    assign retire_rd    = rd;
    assign retire_data  = write_back;
    assign store_valid  = mem_write & ~reset; // No stray stores while loading
    assign store_addr   = alu_result;
    assign store_data   = rs2_data;

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 3
) (
    input  wire  hold,  // Keeps reset high while the program is loaded
    output logic clk,
    output logic reset
);
    int unsigned tail = RESET_CYCLES;
    logic        reset_q = 1'b1;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Trailing reset cycles counted once the hold is released
    always @(posedge clk) begin
        if (hold) begin
            tail <= RESET_CYCLES;
        end else if (tail != 0) begin
            tail <= tail - 1;
        end
    end

    always @(negedge clk) begin
        reset_q <= (tail != 0); // Reset moves on the falling edge only
    end

    assign reset = reset_q;

endmodule

`default_nettype wire

// File: bench/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module tb_top;
    import rv_pkg::*;

    localparam int RESET_LIMIT = 20;
    localparam int RUN_LIMIT   = 400;

    logic       clk;
    logic       reset;
    logic       hold;
    logic       load_en;
    imem_addr_t load_addr;
    word_t      load_data;
    word_t      pc;
    logic       retire_valid;
    reg_idx_t   retire_rd;
    word_t      retire_data;
    logic       store_valid;
    word_t      store_addr;
    word_t      store_data;

    word_t prog [$];                 // Program image, one word per instruction
    string tags [$];                 // Test name of each instruction
    string section;
    word_t model_rf [`RV_REG_COUNT];
    word_t model_mem [word_t];       // Keyed by word index
    word_t model_pc;

    tb_clock clock_gen (.hold(hold), .clk(clk), .reset(reset));

    rv_core_top dut (.clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
                     .load_data(load_data), .pc(pc), .retire_valid(retire_valid),
                     .retire_rd(retire_rd), .retire_data(retire_data),
                     .store_valid(store_valid), .store_addr(store_addr),
                     .store_data(store_data));

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic value_error(string test, string what, word_t expected, word_t actual);
        $display("FAILED %s %s: expected %h, actual %h", test, what, expected, actual);
        stop_with_failure();
    endtask

    task automatic timeout_abort(string what);
        $display("Timed out waiting for %s", what);
        stop_with_failure();
    endtask

    // Strobes stay gated and the PC parked while reset is high
    reset_quiet: assert property (@(posedge clk)
        reset |-> (pc == '0 && !retire_valid && !store_valid))
        else begin
            $display("Core was active while held in reset");
            stop_with_failure();
        end

    function automatic word_t i_type(logic [6:0] opc, int f3, int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic word_t r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP};
    endfunction

    function automatic word_t s_type(int rs2, int rs1, int imm);
        logic [11:0] off;
        off = 12'(imm);
        return {off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], STORE};
    endfunction

    function automatic word_t b_type(int f3, int rs1, int rs2, int imm);
        logic [12:0] off;
        off = 13'(imm);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'(f3), off[4:1], off[11], BRANCH};
    endfunction

    task automatic emit(word_t ins);
        prog.push_back(ins);
        tags.push_back(section);
    endtask

    // No LUI, so a full word is built from 10, 11 and 11 bit pieces
    task automatic load_value(int rd, word_t value);
        emit(i_type(OP_IMM, 0, rd, 0, int'(value[31:22])));
        emit(i_type(OP_IMM, 1, rd, rd, 11));
        emit(i_type(OP_IMM, 6, rd, rd, int'(value[21:11])));
        emit(i_type(OP_IMM, 1, rd, rd, 11));
        emit(i_type(OP_IMM, 6, rd, rd, int'(value[10:0])));
    endtask

    // Order is add sub sll slt sltu xor srl sra or and
    task automatic reg_ops(int rs1, int rs2, int first_rd);
        int f3;
        for (int k = 0; k < 10; k++) begin
            f3 = (k <= 1) ? 0 : (k <= 6) ? k - 1 : (k == 7) ? 5 : k - 2;
            emit(r_type((k == 1 || k == 7) ? 32 : 0, f3, first_rd + k, rs1, rs2));
        end
    endtask

    task automatic branch_pair(int f3, int rs1, int rs2);
        emit(b_type(f3, rs1, rs2, 8));
        emit(i_type(OP_IMM, 0, 31, 31, 1)); // Skipped when the branch is taken
    endtask

    task automatic build_program();
        section = "x0 write";
        emit(i_type(OP_IMM, 0, 0, 0, 123));
        section = "operand setup";
        load_value(1, $urandom | 32'h80000000);
        load_value(2, $urandom);
        load_value(3, $urandom);
        load_value(4, $urandom | 32'h80000000);
        section = "reg-reg ops";
        reg_ops(1, 2, 10);
        reg_ops(4, 3, 20);
        section = "immediate ops";
        emit(i_type(OP_IMM, 0, 10, 1, -5));
        emit(i_type(OP_IMM, 2, 11, 1, -1));
        emit(i_type(OP_IMM, 3, 12, 2, -1));
        emit(i_type(OP_IMM, 4, 13, 2, -1));
        emit(i_type(OP_IMM, 6, 14, 4, -2048));
        emit(i_type(OP_IMM, 7, 15, 1, -256));
        emit(i_type(OP_IMM, 1, 16, 2, 7));
        emit(i_type(OP_IMM, 5, 17, 1, 13));
        emit(i_type(OP_IMM, 5, 18, 1, 1024 + 13)); // srai
        section = "store and load";
        emit(i_type(OP_IMM, 0, 7, 0, 256));
        emit(s_type(1, 7, 0));
        emit(s_type(2, 7, -4));
        emit(s_type(4, 7, 40));
        emit(i_type(LOAD, 2, 20, 7, 0));
        emit(i_type(LOAD, 2, 21, 7, -4));
        emit(i_type(LOAD, 2, 22, 7, 40));
        emit(i_type(LOAD, 2, 23, 7, 100)); // Never written
        section = "x0 operand";
        emit(r_type(0, 0, 0, 1, 2));
        emit(r_type(0, 0, 29, 0, 1));
        emit(r_type(32, 0, 30, 0, 2));
        section = "branch";
        emit(i_type(OP_IMM, 0, 5, 0, -1));
        emit(i_type(OP_IMM, 0, 6, 0, 1));
        branch_pair(0, 5, 5);
        branch_pair(0, 5, 6);
        branch_pair(1, 5, 6);
        branch_pair(1, 5, 5);
        branch_pair(4, 5, 6);
        branch_pair(4, 6, 5);
        branch_pair(5, 6, 5);
        branch_pair(5, 5, 6);
        branch_pair(6, 6, 5);
        branch_pair(6, 5, 6);
        branch_pair(7, 5, 6);
        branch_pair(7, 6, 5);
    endtask

    function automatic logic signed_less(word_t a, word_t b);
        return (a ^ 32'h80000000) < (b ^ 32'h80000000);
    endfunction

    // Alt is instruction bit 30
    function automatic word_t arith(logic [2:0] f3, logic alt, word_t a, word_t b);
        word_t sign_fill;
        sign_fill = a[31] ? ~(32'hffffffff >> b[4:0]) : '0;
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return word_t'(signed_less(a, b));
            3'd3:    return word_t'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return (a >> b[4:0]) | (alt ? sign_fill : '0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_cond(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return signed_less(a, b);
            3'd5:    return !signed_less(a, b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // One instruction of the reference model against the current DUT cycle
    task automatic check_and_step();
        int    idx;
        word_t ins;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        word_t next_pc;
        logic  writes;
        string name;
        idx     = int'(model_pc >> 2);
        ins     = (idx < prog.size()) ? prog[idx] : '0;
        name    = (idx < prog.size()) ? tags[idx] : "idle";
        a       = model_rf[ins[19:15]];
        b       = model_rf[ins[24:20]];
        res     = '0;
        addr    = '0;
        writes  = 1'b0;
        next_pc = model_pc + 4;
        case (ins[6:0])
            OP: begin
                writes = 1'b1;
                res    = arith(ins[14:12], ins[30], a, b);
            end
            OP_IMM: begin
                writes = 1'b1;
                res    = arith(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, sext12(ins[31:20]));
            end
            LOAD: begin
                writes = 1'b1;
                addr   = a + sext12(ins[31:20]);
                res    = model_mem.exists(addr >> 2) ? model_mem[addr >> 2] : '0;
            end
            STORE: addr = a + sext12({ins[31:25], ins[11:7]});
            BRANCH: begin
                if (branch_cond(ins[14:12], a, b)) begin
                    next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                          ins[11:8], 1'b0};
                end
            end
            default: begin
                // No-op, only the PC moves
            end
        endcase

        assert (pc == model_pc) else value_error(name, "pc", model_pc, pc);
        assert (retire_valid == (writes && ins[11:7] != '0))
            else value_error(name, "retire_valid", word_t'(writes && ins[11:7] != '0),
                             word_t'(retire_valid));
        if (retire_valid) begin
            assert (retire_rd == ins[11:7])
                else value_error(name, "retire_rd", word_t'(ins[11:7]), word_t'(retire_rd));
            assert (retire_data == res) else value_error(name, "retire_data", res, retire_data);
        end
        assert (store_valid == (ins[6:0] == STORE))
            else value_error(name, "store_valid", word_t'(ins[6:0] == STORE),
                             word_t'(store_valid));
        if (store_valid) begin
            assert (store_addr == addr) else value_error(name, "store_addr", addr, store_addr);
            assert (store_data == b) else value_error(name, "store_data", b, store_data);
        end

        if (writes && ins[11:7] != '0) begin
            model_rf[ins[11:7]] = res;
        end
        if (ins[6:0] == STORE) begin
            model_mem[addr >> 2] = b;
        end
        model_pc = next_pc;
    endtask

    initial begin
        int    waited;
        word_t end_pc;
        word_t probe [2];
        hold       = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        model_pc   = '0;
        foreach (model_rf[i]) begin
            model_rf[i] = '0;
        end
        void'($urandom(55));
        build_program();
        end_pc = word_t'(4 * prog.size());

        // Address 0 briefly holds a register write, then a store, while reset is high
        probe[0] = i_type(OP_IMM, 0, 1, 0, 1);
        probe[1] = s_type(0, 0, 0);
        foreach (probe[i]) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = '0;
            load_data = probe[i];
        end

        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = imem_addr_t'(i);
            load_data = prog[i];
        end
        @(negedge clk);
        load_en = 1'b0;
        hold    = 1'b0;

        // Wake on the reset edge itself so the cycle at address 0 is not missed
        waited = 0;
        while (reset) begin
            if (waited == RESET_LIMIT) begin
                timeout_abort("reset release");
            end
            @(negedge clk or negedge reset);
            waited++;
        end

        waited = 0;
        while (model_pc != end_pc) begin
            if (waited == RUN_LIMIT) begin
                timeout_abort("the program to finish");
            end
            check_and_step();
            @(negedge clk);
            waited++;
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/rv_pkg.sv
src/pc_counter.sv
src/instr_mem.sv
decode/control_decoder.sv
decode/reg_file.sv
execute/alu.sv
execute/branch_compare.sv
src/data_mem.sv
src/rv_core_top.sv
bench/tb_clock.sv
bench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^ALL CHECKS PASSED$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
